// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f --top-module tb_exec_core
	@out="$$(./obj_dir/Vtb_exec_core)"; echo "$$out"; echo "$$out" | grep -q "^sim passed$$"

clean:
	rm -rf obj_dir

// ==== all.f ====
hdl/rv_isa_pkg.sv
hdl/exec_cfg_pkg.sv
hdl/axil_instr_port.sv
hdl/instr_decode.sv
hdl/int_reg_file.sv
hdl/alu_execute.sv
hdl/exec_core_top.sv
verification/tb_exec_core.sv

// ==== hdl/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute #(
    parameter int XLEN = 32
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_de_valid,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_de_rd,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_de_rs1,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_de_rs2,
    input  logic [XLEN-1:0]                    i_de_op_a,
    input  logic [XLEN-1:0]                    i_de_op_b,
    input  logic [XLEN-1:0]                    i_de_imm,
    input  logic                               i_de_use_imm,
    input  exec_cfg_pkg::alu_op_e              i_de_alu_op,
    output logic                               o_wr_en,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_wr_idx,
    output logic [XLEN-1:0]                    o_wr_data,
    output logic                               o_busy
);

    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    fwd_sel_e           w_fwd_a;
    fwd_sel_e           w_fwd_b;
    logic [XLEN-1:0]    w_src_a;
    logic [XLEN-1:0]    w_src_b;
    logic [XLEN-1:0]    w_op_b;
    logic [SHAMT_W-1:0] w_shamt;
    logic [XLEN-1:0]    w_result;

    // forwarding ---------------------------------------------------------

    // only the stage ahead; older results come through the register file
    assign w_fwd_a = (o_wr_en && (o_wr_idx != '0) && (o_wr_idx == i_de_rs1)) ? FWD_EW : FWD_REG;
    assign w_fwd_b = (o_wr_en && (o_wr_idx != '0) && (o_wr_idx == i_de_rs2)) ? FWD_EW : FWD_REG;

    assign w_src_a = (w_fwd_a == FWD_EW) ? o_wr_data : i_de_op_a;
    assign w_src_b = (w_fwd_b == FWD_EW) ? o_wr_data : i_de_op_b;
    assign w_op_b  = i_de_use_imm ? i_de_imm : w_src_b;
    assign w_shamt = w_op_b[SHAMT_W-1:0];

    // ALU ----------------------------------------------------------------

    always_comb begin
        case (i_de_alu_op)
            ALU_ADD:  w_result = w_src_a + w_op_b;
            ALU_SUB:  w_result = w_src_a - w_op_b;
            ALU_SLL:  w_result = w_src_a << w_shamt;
            ALU_SLT:  w_result = XLEN'($signed(w_src_a) < $signed(w_op_b));
            ALU_SLTU: w_result = XLEN'(w_src_a < w_op_b);
            ALU_XOR:  w_result = w_src_a ^ w_op_b;
            ALU_SRL:  w_result = w_src_a >> w_shamt;
            ALU_SRA:  w_result = $signed(w_src_a) >>> w_shamt;
            ALU_OR:   w_result = w_src_a | w_op_b;
            ALU_AND:  w_result = w_src_a & w_op_b;
            default:  w_result = '0;
        endcase
    end

    // E/W register, also the write port of the register file
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_wr_en <= 1'b0;
        end else begin
            o_wr_en <= i_de_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_de_valid) begin
            o_wr_idx  <= i_de_rd;
            o_wr_data <= w_result;
        end
    end

    assign o_busy = i_de_valid || o_wr_en;

    // a forwarded value always comes from an instruction that left D/E last cycle
    a_fwd_from_ew : assert property (@(posedge i_clk) disable iff (i_rst)
        (w_fwd_a == FWD_EW) || (w_fwd_b == FWD_EW) |-> o_wr_en && $past(i_de_valid));

endmodule

// ==== hdl/axil_instr_port.sv ====
`timescale 1ns/1ps

module axil_instr_port #(
    parameter int XLEN = 32
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_awvalid,
    output logic                               o_awready,
    input  logic [11:0]                        i_awaddr,
    input  logic                               i_wvalid,
    output logic                               o_wready,
    input  logic [rv_isa_pkg::INSTR_W-1:0]     i_wdata,
    output logic                               o_bvalid,
    output logic [1:0]                         o_bresp,
    input  logic                               i_bready,
    input  logic                               i_arvalid,
    output logic                               o_arready,
    input  logic [11:0]                        i_araddr,
    output logic                               o_rvalid,
    output logic [XLEN-1:0]                    o_rdata,
    output logic [1:0]                         o_rresp,
    input  logic                               i_rready,
    input  logic                               i_busy,
    input  logic [XLEN-1:0]                    i_host_rdata,
    output logic                               o_issue,
    output logic [rv_isa_pkg::INSTR_W-1:0]     o_instr,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_host_ridx
);

    import rv_isa_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic w_wr_fire;
    logic w_wr_ok;

    // write channels ------------------------------------------------------

    // aw and w are only taken together
    assign w_wr_fire = i_awvalid && i_wvalid && !o_bvalid;
    assign w_wr_ok   = (i_awaddr == 12'h000) &&
                       (i_wdata[OPC_W-1:0] inside {OPC_OP, OPC_OP_IMM, OPC_LUI});

    assign o_awready = w_wr_fire;
    assign o_wready  = w_wr_fire;
    assign o_issue   = w_wr_fire && w_wr_ok;  // rejected writes never reach decode
    assign o_instr   = i_wdata;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_bvalid <= 1'b0;
        end else if (w_wr_fire) begin
            o_bvalid <= 1'b1;
        end else if (i_bready) begin
            o_bvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_wr_fire) begin
            o_bresp <= w_wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    // read channels -------------------------------------------------------

    // hold reads off until the pipe has drained into the register file
    assign o_arready   = i_arvalid && !i_busy && !w_wr_fire && !o_rvalid;
    assign o_host_ridx = i_araddr[REG_IDX_W+1:2];  // word address
    assign o_rresp     = RESP_OKAY;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_rvalid <= 1'b0;
        end else if (o_arready) begin
            o_rvalid <= 1'b1;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_arready) begin
            o_rdata <= i_host_rdata;  // stays put under back-pressure
        end
    end

    // a write response is held, unchanged, until the host takes it
    a_bvalid_held : assert property (@(posedge i_clk) disable iff (i_rst)
        o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp));

endmodule

// ==== hdl/exec_cfg_pkg.sv ====
package exec_cfg_pkg;

    // decode -> execute operation select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // operand source in execute
    typedef enum logic {
        FWD_REG = 1'b0,  // value read in decode
        FWD_EW  = 1'b1   // result sitting in E/W
    } fwd_sel_e;

endpackage

// ==== hdl/exec_core_top.sv ====
`timescale 1ns/1ps

module exec_core_top #(
    parameter int XLEN = rv_isa_pkg::XLEN_DEFAULT
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_awvalid,
    output logic                               o_awready,
    input  logic [11:0]                        i_awaddr,
    input  logic                               i_wvalid,
    output logic                               o_wready,
    input  logic [rv_isa_pkg::INSTR_W-1:0]     i_wdata,
    output logic                               o_bvalid,
    output logic [1:0]                         o_bresp,
    input  logic                               i_bready,
    input  logic                               i_arvalid,
    output logic                               o_arready,
    input  logic [11:0]                        i_araddr,
    output logic                               o_rvalid,
    output logic [XLEN-1:0]                    o_rdata,
    output logic [1:0]                         o_rresp,
    input  logic                               i_rready
);

    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic                 w_issue;
    logic [INSTR_W-1:0]   w_instr;
    logic                 w_busy;
    logic [REG_IDX_W-1:0] w_host_ridx;
    logic [XLEN-1:0]      w_host_rdata;
    logic [REG_IDX_W-1:0] w_rs1_idx;
    logic [REG_IDX_W-1:0] w_rs2_idx;
    logic [XLEN-1:0]      w_rs1_data;
    logic [XLEN-1:0]      w_rs2_data;

    // D/E
    logic                 w_de_valid;
    logic [REG_IDX_W-1:0] w_de_rd;
    logic [REG_IDX_W-1:0] w_de_rs1;
    logic [REG_IDX_W-1:0] w_de_rs2;
    logic [XLEN-1:0]      w_de_op_a;
    logic [XLEN-1:0]      w_de_op_b;
    logic [XLEN-1:0]      w_de_imm;
    logic                 w_de_use_imm;
    alu_op_e              w_de_alu_op;

    // E/W writeback
    logic                 w_wr_en;
    logic [REG_IDX_W-1:0] w_wr_idx;
    logic [XLEN-1:0]      w_wr_data;

    axil_instr_port #(.XLEN(XLEN)) u_port (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_awvalid    (i_awvalid),
        .o_awready    (o_awready),
        .i_awaddr     (i_awaddr),
        .i_wvalid     (i_wvalid),
        .o_wready     (o_wready),
        .i_wdata      (i_wdata),
        .o_bvalid     (o_bvalid),
        .o_bresp      (o_bresp),
        .i_bready     (i_bready),
        .i_arvalid    (i_arvalid),
        .o_arready    (o_arready),
        .i_araddr     (i_araddr),
        .o_rvalid     (o_rvalid),
        .o_rdata      (o_rdata),
        .o_rresp      (o_rresp),
        .i_rready     (i_rready),
        .i_busy       (w_busy),
        .i_host_rdata (w_host_rdata),
        .o_issue      (w_issue),
        .o_instr      (w_instr),
        .o_host_ridx  (w_host_ridx)
    );

    instr_decode #(.XLEN(XLEN)) u_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_issue      (w_issue),
        .i_instr      (w_instr),
        .i_rs1_data   (w_rs1_data),
        .i_rs2_data   (w_rs2_data),
        .o_rs1_idx    (w_rs1_idx),
        .o_rs2_idx    (w_rs2_idx),
        .o_de_valid   (w_de_valid),
        .o_de_rd      (w_de_rd),
        .o_de_rs1     (w_de_rs1),
        .o_de_rs2     (w_de_rs2),
        .o_de_op_a    (w_de_op_a),
        .o_de_op_b    (w_de_op_b),
        .o_de_imm     (w_de_imm),
        .o_de_use_imm (w_de_use_imm),
        .o_de_alu_op  (w_de_alu_op)
    );

    int_reg_file #(.XLEN(XLEN)) u_regs (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_rs1_idx    (w_rs1_idx),
        .i_rs2_idx    (w_rs2_idx),
        .i_host_ridx  (w_host_ridx),
        .i_wr_en      (w_wr_en),
        .i_wr_idx     (w_wr_idx),
        .i_wr_data    (w_wr_data),
        .o_rs1_data   (w_rs1_data),
        .o_rs2_data   (w_rs2_data),
        .o_host_rdata (w_host_rdata)
    );

    alu_execute #(.XLEN(XLEN)) u_exec (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_de_valid   (w_de_valid),
        .i_de_rd      (w_de_rd),
        .i_de_rs1     (w_de_rs1),
        .i_de_rs2     (w_de_rs2),
        .i_de_op_a    (w_de_op_a),
        .i_de_op_b    (w_de_op_b),
        .i_de_imm     (w_de_imm),
        .i_de_use_imm (w_de_use_imm),
        .i_de_alu_op  (w_de_alu_op),
        .o_wr_en      (w_wr_en),
        .o_wr_idx     (w_wr_idx),
        .o_wr_data    (w_wr_data),
        .o_busy       (w_busy)
    );

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/1ps

module instr_decode #(
    parameter int XLEN = 32
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic                               i_issue,
    input  logic [rv_isa_pkg::INSTR_W-1:0]     i_instr,
    input  logic [XLEN-1:0]                    i_rs1_data,
    input  logic [XLEN-1:0]                    i_rs2_data,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_rs1_idx,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_rs2_idx,
    output logic                               o_de_valid,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_de_rd,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_de_rs1,
    output logic [rv_isa_pkg::REG_IDX_W-1:0]   o_de_rs2,
    output logic [XLEN-1:0]                    o_de_op_a,
    output logic [XLEN-1:0]                    o_de_op_b,
    output logic [XLEN-1:0]                    o_de_imm,
    output logic                               o_de_use_imm,
    output exec_cfg_pkg::alu_op_e              o_de_alu_op
);

    import rv_isa_pkg::*;
    import exec_cfg_pkg::*;

    logic [OPC_W-1:0] w_opcode;
    funct3_e          w_f3;
    logic             w_is_op;
    logic             w_is_lui;
    logic             w_alt;
    logic [XLEN-1:0]  w_imm;
    alu_op_e          w_alu_op;

    assign w_opcode = i_instr[OPC_W-1:0];
    assign w_f3     = funct3_e'(i_instr[F3_LSB +: 3]);
    assign w_is_op  = (w_opcode == OPC_OP);
    assign w_is_lui = (w_opcode == OPC_LUI);
    assign w_alt    = i_instr[F7_ALT_BIT];

    // lui adds its immediate to x0
    assign o_rs1_idx = w_is_lui ? '0 : i_instr[RS1_LSB +: REG_IDX_W];
    assign o_rs2_idx = i_instr[RS2_LSB +: REG_IDX_W];

    assign w_imm = w_is_lui ?
        XLEN'($signed({i_instr[INSTR_W-1:IMM_U_LSB], {IMM_U_LSB{1'b0}}})) :
        XLEN'($signed(i_instr[INSTR_W-1:IMM_I_LSB]));

    always_comb begin
        w_alu_op = ALU_ADD;
        if (!w_is_lui) begin
            case (w_f3)
                F3_ADD_SUB: w_alu_op = (w_is_op && w_alt) ? ALU_SUB : ALU_ADD;  // no subi
                F3_SLL:     w_alu_op = ALU_SLL;
                F3_SLT:     w_alu_op = ALU_SLT;
                F3_SLTU:    w_alu_op = ALU_SLTU;
                F3_XOR:     w_alu_op = ALU_XOR;
                F3_SRL_SRA: w_alu_op = w_alt ? ALU_SRA : ALU_SRL;
                F3_OR:      w_alu_op = ALU_OR;
                F3_AND:     w_alu_op = ALU_AND;
            endcase
        end
    end

    // D/E register
    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            o_de_valid <= 1'b0;
        end else begin
            o_de_valid <= i_issue;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_issue) begin
            o_de_rd      <= i_instr[RD_LSB +: REG_IDX_W];
            o_de_rs1     <= o_rs1_idx;
            o_de_rs2     <= o_rs2_idx;
            o_de_op_a    <= i_rs1_data;
            o_de_op_b    <= i_rs2_data;
            o_de_imm     <= w_imm;
            o_de_use_imm <= !w_is_op;
            o_de_alu_op  <= w_alu_op;
        end
    end

endmodule

// ==== hdl/int_reg_file.sv ====
`timescale 1ns/1ps

module int_reg_file #(
    parameter int XLEN = 32
) (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_rs1_idx,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_rs2_idx,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_host_ridx,
    input  logic                               i_wr_en,
    input  logic [rv_isa_pkg::REG_IDX_W-1:0]   i_wr_idx,
    input  logic [XLEN-1:0]                    i_wr_data,
    output logic [XLEN-1:0]                    o_rs1_data,
    output logic [XLEN-1:0]                    o_rs2_data,
    output logic [XLEN-1:0]                    o_host_rdata
);

    import rv_isa_pkg::*;

    localparam int NREGS = 2 ** REG_IDX_W;

    logic [XLEN-1:0] r_regs [NREGS];

    // x0 first, then the value being written this cycle
    function automatic logic [XLEN-1:0] read_port(input logic [REG_IDX_W-1:0] idx);
        if (idx == '0) begin
            return '0;
        end
        if (i_wr_en && (i_wr_idx == idx)) begin
            return i_wr_data;
        end
        return r_regs[idx];
    endfunction

    always_comb begin
        o_rs1_data   = read_port(i_rs1_idx);
        o_rs2_data   = read_port(i_rs2_idx);
        o_host_rdata = read_port(i_host_ridx);
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int i = 0; i < NREGS; i++) begin
                r_regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_idx != '0)) begin
            r_regs[i_wr_idx] <= i_wr_data;
        end
    end

    // x0 reads zero on every port, even while it is the write target
    a_x0_zero : assert property (@(posedge i_clk) disable iff (i_rst)
        ((i_rs1_idx != '0) || (o_rs1_data == '0)) &&
        ((i_rs2_idx != '0) || (o_rs2_data == '0)) &&
        ((i_host_ridx != '0) || (o_host_rdata == '0)));

endmodule

// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    localparam int XLEN_DEFAULT = 32;
    localparam int INSTR_W      = 32;
    localparam int REG_IDX_W    = 5;
    localparam int OPC_W        = 7;

    // field positions in the 32-bit encoding
    localparam int RD_LSB     = 7;
    localparam int F3_LSB     = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int IMM_I_LSB  = 20;
    localparam int IMM_U_LSB  = 12;
    localparam int F7_ALT_BIT = 30;  // funct7 bit 5, sub / sra

    // only the integer ALU formats
    typedef enum logic [OPC_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

endpackage

// ==== verification/tb_exec_core.sv ====
`timescale 1ns/1ps

module tb_exec_core;

    localparam int XLEN       = 32;
    localparam int CLK_PERIOD = 20;
    localparam int N_TESTS    = 6;
    localparam int TIMEOUT_NS = N_TESTS * 200 * CLK_PERIOD;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [1:0] OKAY       = 2'b00;
    localparam logic [1:0] SLVERR     = 2'b10;

    logic            i_clk;
    logic            i_rst;
    logic            i_awvalid;
    logic [11:0]     i_awaddr;
    logic            i_wvalid;
    logic [31:0]     i_wdata;
    logic            i_bready;
    logic            i_arvalid;
    logic [11:0]     i_araddr;
    logic            i_rready;
    logic            o_awready;
    logic            o_wready;
    logic            o_bvalid;
    logic [1:0]      o_bresp;
    logic            o_arready;
    logic            o_rvalid;
    logic [XLEN-1:0] o_rdata;
    logic [1:0]      o_rresp;

    logic [XLEN-1:0] model [32];
    logic [31:0]     lfsr_state;
    logic [XLEN-1:0] exp_rdata;
    int              exp_ridx;
    logic [1:0]      exp_bresp;
    int              err_count;
    int              err_mark;
    int              pass_count;

    exec_core_top #(.XLEN(XLEN)) u_dut (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awaddr  (i_awaddr),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wdata   (i_wdata),
        .o_bvalid  (o_bvalid),
        .o_bresp   (o_bresp),
        .i_bready  (i_bready),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_araddr  (i_araddr),
        .o_rvalid  (o_rvalid),
        .o_rdata   (o_rdata),
        .o_rresp   (o_rresp),
        .i_rready  (i_rready)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    // helpers --------------------------------------------------------------

    function automatic void flag_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        err_count++;
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] enc_r(input logic alt, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [1:0] expected_resp(input logic [11:0] addr,
                                                 input logic [31:0] instr);
        if ((addr == 12'h000) &&
            (instr[6:0] == OPC_OP || instr[6:0] == OPC_OP_IMM || instr[6:0] == OPC_LUI)) begin
            return OKAY;
        end
        return SLVERR;
    endfunction

    // RV32I integer rules, applied to the model registers
    function automatic logic [XLEN-1:0] alu_ref(input logic [31:0] instr);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [4:0]      sh;
        logic            alt;
        a   = model[instr[19:15]];
        alt = instr[30];
        if (instr[6:0] == OPC_LUI) begin
            return {instr[31:12], 12'b0};
        end
        if (instr[6:0] == OPC_OP) begin
            b = model[instr[24:20]];
        end else begin
            b = {{20{instr[31]}}, instr[31:20]};
        end
        sh = b[4:0];
        case (instr[14:12])
            3'd0: return (instr[6:0] == OPC_OP && alt) ? a - b : a + b;
            3'd1: return a << sh;
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> sh;
                end
                return a >> sh;
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // mostly one of the last two destinations
    function automatic logic [4:0] pick_src(input logic [4:0] p1, input logic [4:0] p2);
        logic [1:0] sel;
        sel = 2'(take_bits(2));
        if (sel == 2'd0) begin
            return 5'(take_bits(5));
        end
        return (sel == 2'd3) ? p2 : p1;
    endfunction

    function automatic void start_test();
        err_mark = err_count;
    endfunction

    function automatic void end_test(input int num, input string name);
        if (err_count == err_mark) begin
            pass_count++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, err_count - err_mark);
        end
    endfunction

    // bus tasks ------------------------------------------------------------

    // hold > 0 keeps bready low and a second request waiting
    task automatic write_instr(input logic [11:0] addr, input logic [31:0] instr,
                               input int hold);
        exp_bresp = expected_resp(addr, instr);
        i_awaddr  = addr;
        i_wdata   = instr;
        i_awvalid = 1'b1;
        i_wvalid  = 1'b1;
        i_bready  = (hold == 0);
        do @(negedge i_clk); while (!o_bvalid);
        repeat (hold) @(negedge i_clk);
        i_awvalid = 1'b0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b1;
        @(negedge i_clk);
        if (exp_bresp == OKAY && instr[11:7] != 5'd0) begin
            model[instr[11:7]] = alu_ref(instr);
        end
    endtask

    // hold > 0 keeps rready low and the request asserted behind it
    task automatic read_reg(input int idx, input int hold);
        exp_ridx  = idx;
        exp_rdata = model[idx];
        i_araddr  = 12'(idx * 4);
        i_arvalid = 1'b1;
        i_rready  = (hold == 0);
        do @(negedge i_clk); while (!o_rvalid);
        repeat (hold) @(negedge i_clk);
        i_arvalid = 1'b0;
        i_rready  = 1'b1;
        @(negedge i_clk);
    endtask

    task automatic read_all();
        for (int r = 0; r < 32; r++) begin
            read_reg(r, 0);
        end
    endtask

    // checks ---------------------------------------------------------------

    a_rdata : assert property (@(posedge i_clk) disable iff (i_rst)
        o_rvalid && i_rready |-> (o_rdata == exp_rdata) && (o_rresp == OKAY))
        else flag_error($sformatf("read x%0d gave %h resp %0d, expected %h",
                                  exp_ridx, $sampled(o_rdata), $sampled(o_rresp), exp_rdata));

    a_bresp : assert property (@(posedge i_clk) disable iff (i_rst)
        o_bvalid && i_bready |-> o_bresp == exp_bresp)
        else flag_error($sformatf("write response %0d, expected %0d",
                                  $sampled(o_bresp), exp_bresp));

    a_no_aw_while_blocked : assert property (@(posedge i_clk) disable iff (i_rst)
        o_bvalid && !i_bready |-> !o_awready && !o_wready)
        else flag_error("write accepted while a response was pending");

    a_bvalid_kept : assert property (@(posedge i_clk) disable iff (i_rst)
        o_bvalid && !i_bready |=> o_bvalid)
        else flag_error("write response dropped before bready");

    a_rdata_kept : assert property (@(posedge i_clk) disable iff (i_rst)
        o_rvalid && !i_rready |=> $stable(o_rdata))
        else flag_error("read data changed under back-pressure");

    // an issued instruction sits in D/E, then E/W, for the two cycles after acceptance
    a_arready_idle : assert property (@(posedge i_clk) disable iff (i_rst)
        o_arready |-> !o_rvalid &&
                      !$past(o_awready && (exp_bresp == OKAY)) &&
                      !$past(o_awready && (exp_bresp == OKAY), 2))
        else flag_error("read accepted while an instruction was in flight");

    // main sequence --------------------------------------------------------

    initial begin
        logic [31:0] instr;
        logic [4:0]  rd;
        logic [4:0]  prev1;
        logic [4:0]  prev2;
        i_rst      = 1'b1;
        i_awvalid  = 1'b0;
        i_awaddr   = '0;
        i_wvalid   = 1'b0;
        i_wdata    = '0;
        i_bready   = 1'b1;
        i_arvalid  = 1'b0;
        i_araddr   = '0;
        i_rready   = 1'b1;
        lfsr_state = 32'hae64;
        exp_rdata  = '0;
        exp_ridx   = 0;
        exp_bresp  = OKAY;
        err_count  = 0;
        err_mark   = 0;
        pass_count = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        repeat (4) @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);

        start_test();
        read_all();
        end_test(1, "reset values");

        start_test();
        for (int n = 0; n < 40; n++) begin
            if (2'(take_bits(2)) == 2'd0) begin
                instr = {20'(take_bits(20)), 5'(take_bits(5)), OPC_LUI};
            end else begin
                instr = enc_i(12'(take_bits(12)), 5'(take_bits(5)), 3'(take_bits(3)),
                              5'(take_bits(5)));
            end
            write_instr(12'h000, instr, 0);
            read_reg(instr[11:7], 0);
        end
        end_test(2, "immediate and lui");

        start_test();
        prev1 = 5'd1;
        prev2 = 5'd2;
        for (int n = 0; n < 60; n++) begin
            rd    = 5'(take_bits(5));
            instr = enc_r(1'(take_bits(1)), pick_src(prev1, prev2), pick_src(prev1, prev2),
                          3'(take_bits(3)), rd);
            write_instr(12'h000, instr, 0);
            prev2 = prev1;
            prev1 = rd;
        end
        read_all();
        end_test(3, "dependent register ops");

        start_test();
        write_instr(12'h000, enc_i(12'h7ff, 5'd3, 3'd0, 5'd0), 0);
        write_instr(12'h000, {20'habcde, 5'd0, OPC_LUI}, 0);
        write_instr(12'h000, enc_r(1'b1, 5'd2, 5'd1, 3'd0, 5'd0), 0);
        write_instr(12'h000, enc_i(12'h055, 5'd0, 3'd6, 5'd6), 0);
        read_reg(0, 0);
        read_reg(6, 0);
        end_test(4, "x0 destination");

        start_test();
        write_instr(12'h000, {25'h1abc, 7'b0000011}, 0);  // load opcode
        write_instr(12'h004, enc_i(12'h123, 5'd1, 3'd0, 5'd4), 0);
        read_all();
        end_test(5, "rejected writes");

        start_test();
        write_instr(12'h000, enc_i(12'h005, 5'd9, 3'd0, 5'd9), 6);
        write_instr(12'h000, enc_r(1'b0, 5'd9, 5'd9, 3'd0, 5'd10), 0);
        read_reg(9, 5);
        read_reg(10, 0);
        end_test(6, "back-pressure");

        $display("tests passed %0d of %0d, errors %0d", pass_count, N_TESTS, err_count);
        if (err_count == 0 && pass_count == N_TESTS) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
